//--- sources.f
host_chan_pkg.sv
fiu_split_mmio.sv
host_mem_map.sv
mmio_map.sv
mmio_reg_pipe.sv
host_chan_as_mem_with_mmio.sv
tb_host_chan.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the host channel adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_host_chan -f sources.f

# The simulation exits nonzero on failure, the pass line decides the result
output=$(./obj_dir/Vtb_host_chan || true)
echo "$output"
if grep -qx "Result: PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- tb_host_chan.sv
/*
 * Self-checking testbench for the host channel adapter
 * FIU stimulus, AFU MMIO responder model, reference read data
 * function, expected-item queues and the compare process
 */

`timescale 1ns/1ps

module tb_host_chan import host_chan_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_MEM_REQS   = 40;
    localparam int N_MEM_RSPS   = 30;
    localparam int N_MMIO_BEATS = 40;
    // All tests together need fewer than 1000 cycles
    // The limit leaves about twice that as margin
    localparam int TIMEOUT_CYCLES = 2000;
    // Wide enough for the largest packed struct that is compared
    localparam int CHK_W = 640;

    // Each expected item carries the cycle in which it must show up
    typedef struct packed {
        int          due;
        t_fiu_tx_mem item;
    } t_exp_tx_mem;

    typedef struct packed {
        int           due;
        t_afu_mem_rsp item;
    } t_exp_mem_rsp;

    typedef struct packed {
        int        due;
        t_mmio_req item;
    } t_exp_mmio_req;

    logic         clk = 1'b0;
    logic         rst;
    t_fiu_rx      fiu_rx;
    logic         fiu_almost_full;
    t_fiu_tx_mem  fiu_tx_mem;
    t_fiu_tx_mmio fiu_tx_mmio;
    t_afu_mem_req mem_req;
    t_afu_mem_rsp mem_rsp;
    logic         mem_busy;
    t_mmio_req    mmio_req;
    t_mmio_rsp    mmio_rsp = '0;
    int           cyc = 0;
    string        test_name = "reset";

    t_exp_tx_mem   exp_tx_mem_q[$];
    t_exp_mem_rsp  exp_mem_rsp_q[$];
    t_exp_mmio_req exp_mmio_req_q[$];
    // MMIO read responses in host request order, and their due cycles
    t_fiu_tx_mmio  exp_mmio_rsp_q[$];
    int            mmio_rsp_due_q[$];
    // Reads the AFU model still owes, with the cycle it may answer
    logic [MMIO_ADDR_W-1:0] afu_rd_addr_q[$];
    int                     afu_rd_time_q[$];

    host_chan_as_mem_with_mmio i_host_chan_as_mem_with_mmio (
        .clk             (clk),
        .rst             (rst),
        .fiu_rx          (fiu_rx),
        .fiu_almost_full (fiu_almost_full),
        .fiu_tx_mem      (fiu_tx_mem),
        .fiu_tx_mmio     (fiu_tx_mmio),
        .mem_req         (mem_req),
        .mem_rsp         (mem_rsp),
        .mem_busy        (mem_busy),
        .mmio_req        (mmio_req),
        .mmio_rsp        (mmio_rsp)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    // Read data the AFU returns for an MMIO address
    // Every bit of the address shows up in the result
    function automatic logic [MMIO_DATA_W-1:0] expected_mmio_data(
        input logic [MMIO_ADDR_W-1:0] addr);
        return {addr ^ 16'h3c5a, ~addr, addr + 16'h0123, {addr[7:0], addr[15:8]}};
    endfunction

    function automatic logic [DATA_W-1:0] random_line();
        logic [DATA_W-1:0] v;
        for (int i = 0; i < DATA_W / 32; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic bit queues_empty();
        return exp_tx_mem_q.size() == 0 && exp_mem_rsp_q.size() == 0 &&
               exp_mmio_req_q.size() == 0 && exp_mmio_rsp_q.size() == 0 &&
               mmio_rsp_due_q.size() == 0 && afu_rd_addr_q.size() == 0;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check(input string name, input logic [CHK_W-1:0] expected,
                         input logic [CHK_W-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s %s expected %0h actual %0h",
                                     test_name, name, expected, actual));
        end
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            report_failure("Timeout: the tests did not finish within the cycle limit");
        end
    end

    // ========================================
    // AFU MMIO responder
    // ========================================

    // Answers reads strictly in order, each after 0 to 5 idle cycles
    always @(negedge clk) begin : afu_mmio_responder
        logic [MMIO_ADDR_W-1:0] addr;

        mmio_rsp.valid = 1'b0;
        if (!rst) begin
            if (mmio_req.valid && !mmio_req.wr) begin
                afu_rd_addr_q.push_back(mmio_req.addr);
                afu_rd_time_q.push_back(cyc + int'($urandom % 6));
            end
            if (afu_rd_time_q.size() != 0 && afu_rd_time_q[0] <= cyc) begin
                addr = afu_rd_addr_q.pop_front();
                afu_rd_time_q.delete(0);
                mmio_rsp.valid = 1'b1;
                mmio_rsp.data  = expected_mmio_data(addr);
                mmio_rsp_due_q.push_back(cyc + 3);
            end
        end
    end

    // ========================================
    // Compare process
    // ========================================

    always @(negedge clk) begin : compare_outputs
        t_exp_tx_mem   e_mem;
        t_exp_mem_rsp  e_rsp;
        t_exp_mmio_req e_req;
        t_mmio_req     act_req;

        if (!rst) begin
            if (fiu_tx_mem.valid) begin
                if (exp_tx_mem_q.size() == 0) begin
                    report_failure("An unexpected request appeared on fiu_tx_mem");
                end else begin
                    e_mem = exp_tx_mem_q.pop_front();
                    check("fiu_tx_mem cycle", CHK_W'(e_mem.due), CHK_W'(cyc));
                    check("fiu_tx_mem", CHK_W'(e_mem.item), CHK_W'(fiu_tx_mem));
                end
            end else if (exp_tx_mem_q.size() != 0 && exp_tx_mem_q[0].due <= cyc) begin
                report_failure("An expected request never appeared on fiu_tx_mem");
            end

            if (mem_rsp.valid) begin
                if (exp_mem_rsp_q.size() == 0) begin
                    report_failure("An unexpected response appeared on mem_rsp");
                end else begin
                    e_rsp = exp_mem_rsp_q.pop_front();
                    check("mem_rsp cycle", CHK_W'(e_rsp.due), CHK_W'(cyc));
                    check("mem_rsp", CHK_W'(e_rsp.item), CHK_W'(mem_rsp));
                end
            end else if (exp_mem_rsp_q.size() != 0 && exp_mem_rsp_q[0].due <= cyc) begin
                report_failure("An expected response never appeared on mem_rsp");
            end

            if (mmio_req.valid) begin
                if (exp_mmio_req_q.size() == 0) begin
                    report_failure("An unexpected request appeared on mmio_req");
                end else begin
                    e_req = exp_mmio_req_q.pop_front();
                    act_req = mmio_req;
                    // Data only matters for writes
                    if (!act_req.wr) begin
                        act_req.data = '0;
                    end
                    check("mmio_req cycle", CHK_W'(e_req.due), CHK_W'(cyc));
                    check("mmio_req", CHK_W'(e_req.item), CHK_W'(act_req));
                end
            end else if (exp_mmio_req_q.size() != 0 && exp_mmio_req_q[0].due <= cyc) begin
                report_failure("An expected request never appeared on mmio_req");
            end

            if (fiu_tx_mmio.valid) begin
                if (exp_mmio_rsp_q.size() == 0 || mmio_rsp_due_q.size() == 0) begin
                    report_failure("An unexpected read response appeared on fiu_tx_mmio");
                end else begin
                    check("fiu_tx_mmio cycle", CHK_W'(mmio_rsp_due_q.pop_front()), CHK_W'(cyc));
                    check("fiu_tx_mmio", CHK_W'(exp_mmio_rsp_q.pop_front()),
                          CHK_W'(fiu_tx_mmio));
                end
            end else if (mmio_rsp_due_q.size() != 0 && mmio_rsp_due_q[0] <= cyc) begin
                report_failure("An expected read response never appeared on fiu_tx_mmio");
            end
        end
    end

    // ========================================
    // Tests
    // ========================================

    task automatic check_reset_and_busy();
        test_name = "reset_and_busy";
        check("fiu_tx_mem valid", '0, CHK_W'(fiu_tx_mem.valid));
        check("fiu_tx_mmio valid", '0, CHK_W'(fiu_tx_mmio.valid));
        check("mem_rsp valid", '0, CHK_W'(mem_rsp.valid));
        check("mmio_req valid", '0, CHK_W'(mmio_req.valid));
        check("mem_busy", '0, CHK_W'(mem_busy));
        // Almost full must reach mem_busy after one clock edge
        fiu_almost_full = 1'b1;
        @(negedge clk);
        check("mem_busy", CHK_W'(1), CHK_W'(mem_busy));
        fiu_almost_full = 1'b0;
        @(negedge clk);
        check("mem_busy", '0, CHK_W'(mem_busy));
    endtask

    task automatic issue_mem_requests();
        t_exp_tx_mem e;
        test_name = "mem_requests";
        for (int i = 0; i < N_MEM_REQS; i++) begin
            while (mem_busy) begin
                @(negedge clk);
            end
            mem_req.valid = 1'b1;
            mem_req.op    = ($urandom % 2 == 0) ? mem_rd : mem_wr;
            mem_req.addr  = ADDR_W'({$urandom, $urandom});
            mem_req.id    = ID_W'($urandom);
            mem_req.data  = random_line();
            // The FIU request carries the AFU id in mdata
            e.due        = cyc + 1;
            e.item.valid = 1'b1;
            e.item.op    = mem_req.op;
            e.item.addr  = mem_req.addr;
            e.item.mdata = mem_req.id;
            e.item.data  = mem_req.data;
            exp_tx_mem_q.push_back(e);
            @(negedge clk);
            mem_req.valid = 1'b0;
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    task automatic inject_mem_responses();
        t_fiu_rx      beats [N_MEM_RSPS];
        t_fiu_rx      tmp;
        t_exp_mem_rsp e;
        int           k;
        test_name = "mem_responses";
        for (int i = 0; i < N_MEM_RSPS; i++) begin
            beats[i]         = '0;
            beats[i].valid   = 1'b1;
            beats[i].rx_type = (i % 2 == 0) ? rx_rd_rsp : rx_wr_rsp;
            beats[i].mdata   = ID_W'($urandom);
            beats[i].data    = random_line();
        end
        // Shuffle so reads and writes come back in no fixed order
        for (int i = N_MEM_RSPS - 1; i > 0; i--) begin
            k        = int'($urandom % (i + 1));
            tmp      = beats[i];
            beats[i] = beats[k];
            beats[k] = tmp;
        end
        for (int i = 0; i < N_MEM_RSPS; i++) begin
            fiu_rx       = beats[i];
            e.due        = cyc + 2;
            e.item.valid = 1'b1;
            e.item.op    = (beats[i].rx_type == rx_wr_rsp) ? mem_wr : mem_rd;
            e.item.id    = beats[i].mdata;
            // Write responses return no data
            e.item.data  = (beats[i].rx_type == rx_wr_rsp) ? '0 : beats[i].data;
            exp_mem_rsp_q.push_back(e);
            @(negedge clk);
            fiu_rx.valid = 1'b0;
            repeat ($urandom % 2) @(negedge clk);
        end
    endtask

    task automatic drive_mmio_traffic();
        t_exp_mmio_req e;
        t_fiu_tx_mmio  r;
        logic          is_rd;
        test_name = "mmio";
        for (int i = 0; i < N_MMIO_BEATS; i++) begin
            is_rd = ($urandom % 2 == 0);
            // The host keeps no more than MAX_MMIO_RD_REQS reads open
            while (is_rd && exp_mmio_rsp_q.size() >= MAX_MMIO_RD_REQS) begin
                @(negedge clk);
            end
            fiu_rx           = '0;
            fiu_rx.valid     = 1'b1;
            fiu_rx.rx_type   = is_rd ? rx_mmio_rd : rx_mmio_wr;
            fiu_rx.mmio_addr = MMIO_ADDR_W'($urandom);
            fiu_rx.tid       = TID_W'($urandom);
            fiu_rx.data      = random_line();
            e.due            = cyc + 4;
            e.item.valid     = 1'b1;
            e.item.wr        = !is_rd;
            e.item.addr      = fiu_rx.mmio_addr;
            e.item.data      = is_rd ? '0 : fiu_rx.data[MMIO_DATA_W-1:0];
            exp_mmio_req_q.push_back(e);
            if (is_rd) begin
                r.valid = 1'b1;
                r.tid   = fiu_rx.tid;
                r.data  = expected_mmio_data(fiu_rx.mmio_addr);
                exp_mmio_rsp_q.push_back(r);
            end
            @(negedge clk);
            fiu_rx.valid = 1'b0;
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin : stimulus
        void'($urandom(32'hea28));
        rst             = 1'b1;
        fiu_rx          = '0;
        fiu_almost_full = 1'b0;
        mem_req         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reset_and_busy();
        issue_mem_requests();
        inject_mem_responses();
        drive_mmio_traffic();

        // Drain, then idle a little so stray outputs get caught
        while (!queues_empty()) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        if (queues_empty()) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_failure("Expected items were still pending at the end of the run");
        end
    end

endmodule

//--- host_chan_as_mem_with_mmio.sv
/*
 * host_chan_as_mem_with_mmio
 * Top level: FIU split, host memory mapping,
 * MMIO mapping and the MMIO register pipe
 */

`timescale 1ns/1ps

module host_chan_as_mem_with_mmio import host_chan_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // FIU side
    input  t_fiu_rx      fiu_rx,
    input  logic         fiu_almost_full,
    output t_fiu_tx_mem  fiu_tx_mem,
    output t_fiu_tx_mmio fiu_tx_mmio,

    // AFU side
    input  t_afu_mem_req mem_req,
    output t_afu_mem_rsp mem_rsp,
    output logic         mem_busy,
    output t_mmio_req    mmio_req,
    input  t_mmio_rsp    mmio_rsp
);

    t_fiu_rx   mmio_rx;
    t_fiu_rx   mem_rx;
    t_mmio_req map_req;
    t_mmio_rsp map_rsp;

    // Separate MMIO traffic from host memory responses first
    fiu_split_mmio i_fiu_split_mmio (
        .clk     (clk),
        .rst     (rst),
        .fiu_rx  (fiu_rx),
        .mmio_rx (mmio_rx),
        .mem_rx  (mem_rx)
    );

    host_mem_map i_host_mem_map (
        .clk             (clk),
        .rst             (rst),
        .mem_req         (mem_req),
        .fiu_tx_mem      (fiu_tx_mem),
        .fiu_almost_full (fiu_almost_full),
        .mem_busy        (mem_busy),
        .mem_rx          (mem_rx),
        .mem_rsp         (mem_rsp)
    );

    mmio_map i_mmio_map (
        .clk         (clk),
        .rst         (rst),
        .mmio_rx     (mmio_rx),
        .afu_req     (map_req),
        .afu_rsp     (map_rsp),
        .fiu_tx_mmio (fiu_tx_mmio)
    );

    // Register stages sit between the MMIO mapper and the AFU
    mmio_reg_pipe i_mmio_reg_pipe (
        .clk     (clk),
        .rst     (rst),
        .req_in  (map_req),
        .req_out (mmio_req),
        .rsp_in  (mmio_rsp),
        .rsp_out (map_rsp)
    );

endmodule

//--- mmio_reg_pipe.sv
/*
 * mmio_reg_pipe
 * MMIO_REG_STAGES deep register chains for the MMIO request
 * and the MMIO read response, for timing isolation
 */

`timescale 1ns/1ps

module mmio_reg_pipe import host_chan_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  t_mmio_req req_in,
    output t_mmio_req req_out,
    input  t_mmio_rsp rsp_in,
    output t_mmio_rsp rsp_out
);

    t_mmio_req req_q [MMIO_REG_STAGES];
    t_mmio_rsp rsp_q [MMIO_REG_STAGES];

    // Stage 0 takes the input and each later stage takes its neighbour
    always_ff @(posedge clk) begin
        req_q[0] <= req_in;
        rsp_q[0] <= rsp_in;
        for (int i = 1; i < MMIO_REG_STAGES; i++) begin
            req_q[i] <= req_q[i-1];
            rsp_q[i] <= rsp_q[i-1];
        end

        // Clear only the strobes, the payload may hold stale values
        if (rst) begin
            for (int i = 0; i < MMIO_REG_STAGES; i++) begin
                req_q[i].valid <= 1'b0;
                rsp_q[i].valid <= 1'b0;
            end
        end
    end

    assign req_out = req_q[MMIO_REG_STAGES-1];
    assign rsp_out = rsp_q[MMIO_REG_STAGES-1];

endmodule

//--- mmio_map.sv
/*
 * mmio_map
 * FIU MMIO beats to AFU MMIO requests, with a small FIFO
 * of read tids that pairs in-order AFU read data with
 * the host transaction it answers
 */

`timescale 1ns/1ps

module mmio_map import host_chan_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  t_fiu_rx      mmio_rx,
    output t_mmio_req    afu_req,
    input  t_mmio_rsp    afu_rsp,
    output t_fiu_tx_mmio fiu_tx_mmio
);

    // ========================================
    // Request path
    // ========================================

    logic is_rd;
    logic is_wr;

    always_comb begin
        is_rd = mmio_rx.valid && (mmio_rx.rx_type == rx_mmio_rd);
        is_wr = mmio_rx.valid && (mmio_rx.rx_type == rx_mmio_wr);
    end

    always_ff @(posedge clk) begin
        afu_req.valid <= is_rd || is_wr;
        afu_req.wr    <= (mmio_rx.rx_type == rx_mmio_wr);
        afu_req.addr  <= mmio_rx.mmio_addr;
        // MMIO write data is the low word of the line
        afu_req.data  <= mmio_rx.data[MMIO_DATA_W-1:0];

        if (rst) begin
            afu_req.valid <= 1'b0;
        end
    end

    // ========================================
    // Read tid FIFO
    // ========================================

    // The AFU answers reads in request order, so a plain FIFO is enough.
    // The host keeps at most MAX_MMIO_RD_REQS reads open, which is why
    // there is no full check
    logic [TID_W-1:0]    tid_q [MAX_MMIO_RD_REQS];
    logic [TID_Q_AW-1:0] wr_ptr;
    logic [TID_Q_AW-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (is_rd) begin
            tid_q[wr_ptr] <= mmio_rx.tid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (is_rd) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Each returned read retires the oldest tid
            if (afu_rsp.valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ========================================
    // Response path
    // ========================================

    always_ff @(posedge clk) begin
        fiu_tx_mmio.valid <= afu_rsp.valid;
        fiu_tx_mmio.tid   <= tid_q[rd_ptr];
        fiu_tx_mmio.data  <= afu_rsp.data;

        if (rst) begin
            fiu_tx_mmio.valid <= 1'b0;
        end
    end

endmodule

//--- host_mem_map.sv
/*
 * host_mem_map
 * AFU memory requests to FIU channel 0 and 1 requests,
 * FIU read and write responses back to AFU responses,
 * and the almost full level forwarded as mem_busy
 */

`timescale 1ns/1ps

module host_mem_map import host_chan_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  t_afu_mem_req mem_req,
    output t_fiu_tx_mem  fiu_tx_mem,
    input  logic         fiu_almost_full,
    output logic         mem_busy,
    input  t_fiu_rx      mem_rx,
    output t_afu_mem_rsp mem_rsp
);

    // ========================================
    // Request path
    // ========================================

    // The AFU id rides in mdata so that responses can be matched
    // without any tracking state here
    always_ff @(posedge clk) begin
        fiu_tx_mem.valid <= mem_req.valid;
        fiu_tx_mem.op    <= mem_req.op;
        fiu_tx_mem.addr  <= mem_req.addr;
        fiu_tx_mem.mdata <= mem_req.id;
        fiu_tx_mem.data  <= mem_req.data;

        if (rst) begin
            fiu_tx_mem.valid <= 1'b0;
        end
    end

    // Requests already registered above still go out while busy is high,
    // which CCI-P allows after almost full rises
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_busy <= 1'b0;
        end else begin
            mem_busy <= fiu_almost_full;
        end
    end

    // ========================================
    // Response path
    // ========================================

    logic is_rd_rsp;
    logic is_wr_rsp;

    always_comb begin
        is_rd_rsp = (mem_rx.rx_type == rx_rd_rsp);
        is_wr_rsp = (mem_rx.rx_type == rx_wr_rsp);
    end

    always_ff @(posedge clk) begin
        mem_rsp.valid <= mem_rx.valid && (is_rd_rsp || is_wr_rsp);
        mem_rsp.op    <= is_wr_rsp ? mem_wr : mem_rd;
        mem_rsp.id    <= mem_rx.mdata;
        // Write responses carry no payload
        mem_rsp.data  <= is_wr_rsp ? '0 : mem_rx.data;

        if (rst) begin
            mem_rsp.valid <= 1'b0;
        end
    end

endmodule

//--- fiu_split_mmio.sv
/*
 * fiu_split_mmio
 * Registers the FIU receive stream and steers each beat
 * to the MMIO path or the host memory path
 */

`timescale 1ns/1ps

module fiu_split_mmio import host_chan_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  t_fiu_rx fiu_rx,
    output t_fiu_rx mmio_rx,
    output t_fiu_rx mem_rx
);

    // MMIO requests are the two upper header kinds, everything else is
    // a host memory response
    logic is_mmio;

    always_comb begin
        is_mmio = (fiu_rx.rx_type == rx_mmio_wr) || (fiu_rx.rx_type == rx_mmio_rd);
    end

    // Both outputs carry the same payload copy.
    // Only one of them sees the valid bit of a given beat
    always_ff @(posedge clk) begin
        mmio_rx <= fiu_rx;
        mem_rx  <= fiu_rx;
        mmio_rx.valid <= fiu_rx.valid && is_mmio;
        mem_rx.valid  <= fiu_rx.valid && !is_mmio;

        // Payload is left alone in reset, only the strobes drop
        if (rst) begin
            mmio_rx.valid <= 1'b0;
            mem_rx.valid  <= 1'b0;
        end
    end

endmodule

//--- host_chan_pkg.sv
/*
 * Shared definitions for the host channel adapter
 * Sizing localparams, FIU and AFU packed structs,
 * receive header and memory operation enums
 */

package host_chan_pkg;

    // ========================================
    // Sizing
    // ========================================

    // Host memory line address and data widths
    localparam int ADDR_W = 42;
    localparam int DATA_W = 512;

    // AFU request id, carried through the FIU mdata field
    localparam int ID_W = 16;

    // MMIO address, data and host transaction id widths
    localparam int MMIO_ADDR_W = 16;
    localparam int MMIO_DATA_W = 64;
    localparam int TID_W = 9;

    // The host never has more MMIO reads than this in flight
    localparam int MAX_MMIO_RD_REQS = 4;
    localparam int TID_Q_AW = $clog2(MAX_MMIO_RD_REQS);

    // One forced stage plus one extra timing stage on the MMIO port
    localparam int MMIO_REG_STAGES = 2;

    // ========================================
    // Encodings
    // ========================================

    // Kinds of beats the FIU sends on its receive stream
    typedef enum logic [1:0] {
        rx_rd_rsp  = 2'd0,
        rx_wr_rsp  = 2'd1,
        rx_mmio_wr = 2'd2,
        rx_mmio_rd = 2'd3
    } t_rx_type;

    typedef enum logic {
        mem_rd = 1'b0,
        mem_wr = 1'b1
    } t_mem_op;

    // ========================================
    // Structs
    // ========================================

    // One FIU receive beat, covering memory responses and MMIO requests.
    // MMIO write data sits in the low MMIO_DATA_W bits of data
    typedef struct packed {
        logic                   valid;
        t_rx_type               rx_type;
        logic [ID_W-1:0]        mdata;
        logic [MMIO_ADDR_W-1:0] mmio_addr;
        logic [TID_W-1:0]       tid;
        logic [DATA_W-1:0]      data;
    } t_fiu_rx;

    // Host memory request toward the FIU, on channel 0 or 1 by op
    typedef struct packed {
        logic              valid;
        t_mem_op           op;
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   mdata;
        logic [DATA_W-1:0] data;
    } t_fiu_tx_mem;

    // MMIO read response toward the FIU
    typedef struct packed {
        logic                   valid;
        logic [TID_W-1:0]       tid;
        logic [MMIO_DATA_W-1:0] data;
    } t_fiu_tx_mmio;

    typedef struct packed {
        logic              valid;
        t_mem_op           op;
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } t_afu_mem_req;

    // Responses come back out of order and are matched by id
    typedef struct packed {
        logic              valid;
        t_mem_op           op;
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } t_afu_mem_rsp;

    typedef struct packed {
        logic                   valid;
        logic                   wr;
        logic [MMIO_ADDR_W-1:0] addr;
        logic [MMIO_DATA_W-1:0] data;
    } t_mmio_req;

    typedef struct packed {
        logic                   valid;
        logic [MMIO_DATA_W-1:0] data;
    } t_mmio_rsp;

endpackage
